//--- hw/rom_load_pkg.sv
// ROM download definitions
`default_nettype none

package rom_load_pkg;

    // SDRAM byte offsets of the ROM regions, main starts at 0
    localparam logic [21:0] SND_START = 22'h10000;
    localparam logic [21:0] SCR_START = 22'h14000;
    localparam logic [21:0] OBJ_START = 22'h1C000;
    localparam logic [21:0] PCM_START = 22'h24000;

    // Colour PROM block in the download stream
    localparam logic [24:0] PROM_START = 25'h34000;
    localparam int          PROM_SIZE  = 2048;
    localparam int          PROM_AW    = 11;
    localparam logic [24:0] PROM_END   = PROM_START + 25'(PROM_SIZE);

    // SDRAM word address width
    localparam int PROG_AW = 22;

    // PROM byte that selects the board variant
    localparam logic [PROM_AW-1:0] HYPER_OFFSET = 11'd1;

    // Even bytes land in the upper lane
    localparam bit LANE_SWAP = 1'b1;

    typedef enum logic [2:0] {
        REG_MAIN,
        REG_SND,
        REG_SCR,
        REG_OBJ,
        REG_PCM,
        REG_PROM,
        REG_NONE
    } region_t;

endpackage

`default_nettype wire

//--- hw/rom_dwnld_decode.sv
// Download write decoder
`timescale 1ns/1ps
`default_nettype none

module rom_dwnld_decode
    import rom_load_pkg::*;
(
    input  wire                clk,
    input  wire                arst_n,
    input  wire                downloading,
    input  wire                ioctl_wr,
    input  wire [24:0]         ioctl_addr,
    input  wire [7:0]          ioctl_dout,
    input  wire                rem_stall,
    output logic               dec_valid,
    output region_t            dec_region,
    output logic [PROG_AW-1:0] dec_addr,
    output logic [7:0]         dec_data,
    output logic               is_hyper
);

    logic        accept;
    logic        hold;
    logic        hyper_wr;
    logic [21:0] low_addr;
    logic [24:0] prom_off;
    region_t     in_region;

    assign accept   = downloading && ioctl_wr;
    assign hold     = dec_valid && rem_stall;
    assign low_addr = ioctl_addr[21:0];
    assign prom_off = ioctl_addr - PROM_START;
    assign hyper_wr = accept && (in_region == REG_PROM)
                      && (prom_off[PROM_AW-1:0] == HYPER_OFFSET);

    // PROM and the end of the stream use the full address
    always_comb begin
        if (ioctl_addr >= PROM_END) begin
            in_region = REG_NONE;
        end else if (ioctl_addr >= PROM_START) begin
            in_region = REG_PROM;
        end else if (low_addr >= PCM_START) begin
            in_region = REG_PCM;
        end else if (low_addr >= OBJ_START) begin
            in_region = REG_OBJ;
        end else if (low_addr >= SCR_START) begin
            in_region = REG_SCR;
        end else if (low_addr >= SND_START) begin
            in_region = REG_SND;
        end else begin
            in_region = REG_MAIN;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else if (!hold) begin
            dec_valid <= accept && (in_region != REG_NONE);
        end
    end

    always_ff @(posedge clk) begin
        if (!hold && accept) begin
            dec_region <= in_region;
            dec_data   <= ioctl_dout;
            // PROM items carry their offset inside the PROM block
            if (in_region == REG_PROM) begin
                dec_addr <= {{(PROG_AW-PROM_AW){1'b0}}, prom_off[PROM_AW-1:0]};
            end else begin
                dec_addr <= low_addr;
            end
        end
    end

    // Board variant flag, 8'hFF selects it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            is_hyper <= 1'b0;
        end else if (hyper_wr) begin
            is_hyper <= &ioctl_dout;
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!arst_n) hold |-> !accept
    ) else $error("download write lost while decode stage is stalled");

endmodule

`default_nettype wire

//--- hw/gfx_addr_remap.sv
// Graphics address remap stage
`timescale 1ns/1ps
`default_nettype none

module gfx_addr_remap
    import rom_load_pkg::*;
(
    input  wire                clk,
    input  wire                arst_n,
    input  wire                dec_valid,
    input  region_t            dec_region,
    input  wire [PROG_AW-1:0]  dec_addr,
    input  wire [7:0]          dec_data,
    input  wire                wr_busy,
    output logic               rem_stall,
    output logic               rem_valid,
    output logic               rem_is_prom,
    output logic [PROG_AW-1:0] rem_addr,
    output logic [1:0]         rem_mask,
    output logic [7:0]         rem_data
);

    logic [PROG_AW-1:0] word_addr;
    logic [PROG_AW-1:0] remap_addr;
    logic               lane_upper;
    logic [1:0]         lane_mask;

    assign rem_stall = rem_valid && wr_busy;

    // Lane comes from the byte address before any reordering
    assign word_addr  = {1'b0, dec_addr[PROG_AW-1:1]};
    assign lane_upper = dec_addr[0] ^ LANE_SWAP;
    assign lane_mask  = lane_upper ? 2'b01 : 2'b10;

    // Tile bit reordering on the low word address bits
    always_comb begin
        remap_addr = word_addr;
        case (dec_region)
            REG_SCR: remap_addr[3:0] = {word_addr[2:0], ~word_addr[3]};
            REG_OBJ: remap_addr[4:0] = {word_addr[2:0], ~word_addr[4], ~word_addr[3]};
            REG_PROM: remap_addr = dec_addr;
            default: remap_addr = word_addr;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rem_valid <= 1'b0;
        end else if (!rem_stall) begin
            rem_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!rem_stall && dec_valid) begin
            rem_is_prom <= (dec_region == REG_PROM);
            rem_addr    <= remap_addr;
            rem_data    <= dec_data;
            // PROM writes are full bytes
            rem_mask    <= (dec_region == REG_PROM) ? 2'b11 : lane_mask;
        end
    end

endmodule

`default_nettype wire

//--- hw/sdram_prog_writer.sv
// SDRAM program and PROM writer
`timescale 1ns/1ps
`default_nettype none

module sdram_prog_writer
    import rom_load_pkg::*;
(
    input  wire                clk,
    input  wire                arst_n,
    input  wire                rem_valid,
    input  wire                rem_is_prom,
    input  wire [PROG_AW-1:0]  rem_addr,
    input  wire [1:0]          rem_mask,
    input  wire [7:0]          rem_data,
    input  wire                sdram_ack,
    output logic               wr_busy,
    output logic [PROG_AW-1:0] prog_addr,
    output logic [7:0]         prog_data,
    output logic [1:0]         prog_mask,
    output logic               prog_we,
    output logic               prom_we,
    output logic [PROM_AW-1:0] prom_addr,
    output logic [7:0]         prom_data
);

    typedef enum logic {
        WR_IDLE,
        WR_WAIT_ACK
    } wr_state_t;

    wr_state_t state;
    logic      take;

    assign wr_busy = (state == WR_WAIT_ACK) && !sdram_ack;
    assign take    = !wr_busy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= WR_IDLE;
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= 1'b0;
            if (take) begin
                // Ack cycle can chain straight into the next item
                if (rem_valid && !rem_is_prom) begin
                    state   <= WR_WAIT_ACK;
                    prog_we <= 1'b1;
                end else begin
                    state   <= WR_IDLE;
                    prog_we <= 1'b0;
                    prom_we <= rem_valid && rem_is_prom;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && rem_valid) begin
            if (rem_is_prom) begin
                prom_addr <= rem_addr[PROM_AW-1:0];
                prom_data <= rem_data;
            end else begin
                prog_addr <= rem_addr;
                prog_data <= rem_data;
                prog_mask <= rem_mask;
            end
        end
    end

    a_prog_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        (prog_we && !sdram_ack) |=> (prog_we && $stable(prog_addr))
    ) else $error("prog_addr changed before sdram_ack");

    a_prom_pulse: assert property (
        @(posedge clk) disable iff (!arst_n) prom_we |=> !prom_we
    ) else $error("prom_we high for two cycles");

endmodule

`default_nettype wire

//--- hw/rom_load_top.sv
// ROM download path top
`timescale 1ns/1ps
`default_nettype none

module rom_load_top
    import rom_load_pkg::*;
(
    input  wire                clk,
    input  wire                arst_n,
    input  wire                downloading,
    input  wire                ioctl_wr,
    input  wire [24:0]         ioctl_addr,
    input  wire [7:0]          ioctl_dout,
    input  wire                sdram_ack,
    output logic [PROG_AW-1:0] prog_addr,
    output logic [7:0]         prog_data,
    output logic [1:0]         prog_mask,
    output logic               prog_we,
    output logic               prom_we,
    output logic [PROM_AW-1:0] prom_addr,
    output logic [7:0]         prom_data,
    output logic               dwnld_busy,
    output logic               is_hyper
);

    logic               dec_valid;
    region_t            dec_region;
    logic [PROG_AW-1:0] dec_addr;
    logic [7:0]         dec_data;
    logic               rem_stall;
    logic               rem_valid;
    logic               rem_is_prom;
    logic [PROG_AW-1:0] rem_addr;
    logic [1:0]         rem_mask;
    logic [7:0]         rem_data;
    logic               wr_busy;

    // Busy until every stage has drained
    assign dwnld_busy = downloading | dec_valid | rem_valid | prog_we;

    rom_dwnld_decode u_decode (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .rem_stall   ( rem_stall   ),
        .dec_valid   ( dec_valid   ),
        .dec_region  ( dec_region  ),
        .dec_addr    ( dec_addr    ),
        .dec_data    ( dec_data    ),
        .is_hyper    ( is_hyper    )
    );

    gfx_addr_remap u_remap (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .dec_valid   ( dec_valid   ),
        .dec_region  ( dec_region  ),
        .dec_addr    ( dec_addr    ),
        .dec_data    ( dec_data    ),
        .wr_busy     ( wr_busy     ),
        .rem_stall   ( rem_stall   ),
        .rem_valid   ( rem_valid   ),
        .rem_is_prom ( rem_is_prom ),
        .rem_addr    ( rem_addr    ),
        .rem_mask    ( rem_mask    ),
        .rem_data    ( rem_data    )
    );

    sdram_prog_writer u_writer (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .rem_valid   ( rem_valid   ),
        .rem_is_prom ( rem_is_prom ),
        .rem_addr    ( rem_addr    ),
        .rem_mask    ( rem_mask    ),
        .rem_data    ( rem_data    ),
        .sdram_ack   ( sdram_ack   ),
        .wr_busy     ( wr_busy     ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     ),
        .prom_addr   ( prom_addr   ),
        .prom_data   ( prom_data   )
    );

endmodule

`default_nettype wire

//--- dv/rom_load_tb.sv
// ROM download testbench
`timescale 1ns/1ps
`default_nettype none

module rom_load_tb;

    // Region map of the download stream
    localparam logic [24:0] SCR_BASE  = 25'h14000;
    localparam logic [24:0] OBJ_BASE  = 25'h1C000;
    localparam logic [24:0] PCM_BASE  = 25'h24000;
    localparam logic [24:0] PROM_BASE = 25'h34000;
    localparam logic [24:0] PROM_LAST = 25'h347FF;

    logic        clk = 1'b0;
    logic        arst_n = 1'b0;
    logic        downloading = 1'b0;
    logic        ioctl_wr = 1'b0;
    logic [24:0] ioctl_addr = '0;
    logic [7:0]  ioctl_dout = '0;
    logic        sdram_ack = 1'b0;
    wire  [21:0] prog_addr;
    wire  [7:0]  prog_data;
    wire  [1:0]  prog_mask;
    wire         prog_we;
    wire         prom_we;
    wire  [10:0] prom_addr;
    wire  [7:0]  prom_data;
    wire         dwnld_busy;
    wire         is_hyper;

    logic [24:0] pat_addr [$];
    logic [7:0]  pat_data [$];
    int          pat_dly [$];

    // Expected SDRAM and PROM writes, oldest first
    logic [21:0] exp_addr_q [$];
    logic [7:0]  exp_data_q [$];
    logic [1:0]  exp_mask_q [$];
    int          exp_cyc_q [$];
    int          ack_dly_q [$];
    logic [10:0] exp_paddr_q [$];
    logic [7:0]  exp_pdata_q [$];
    int          exp_pcyc_q [$];

    int          errors = 0;
    int          cycle = 0;
    int          cycle_limit = 100000;
    int          sdram_count = 0;
    int          prom_count = 0;
    logic        exp_hyper = 1'b0;
    logic [7:0]  lfsr = 8'd12;
    logic        pending = 1'b0;
    int          wait_cnt = 0;
    int          cur_dly = 0;
    logic [21:0] held_addr;
    logic [7:0]  held_data;
    logic [1:0]  held_mask;

    rom_load_top uut (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .sdram_ack   ( sdram_ack   ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     ),
        .prom_addr   ( prom_addr   ),
        .prom_data   ( prom_data   ),
        .dwnld_busy  ( dwnld_busy  ),
        .is_hyper    ( is_hyper    )
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("Timeout after %0d cycles, the download never completed", cycle);
            $display("Test failed");
            $finish;
        end
    end

    // Galois LFSR, one step per bit
    task automatic rand_value(input int nbits, output int val);
        logic b;
        val = 0;
        for (int i = 0; i < nbits; i++) begin
            b = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ 8'hB8;
            end
            val = (val << 1) | int'(b);
        end
    endtask

    // Reference model of one accepted download byte
    task automatic predict(input logic [24:0] addr, input logic [7:0] data, input int dly);
        logic [21:0] w;
        logic [21:0] nw;
        logic [24:0] off;
        w  = {1'b0, addr[21:1]};
        nw = w;
        off = addr - PROM_BASE;
        if (addr > PROM_LAST) begin
            // Past the PROM block, nothing comes out
            nw = w;
        end else if (addr >= PROM_BASE) begin
            exp_paddr_q.push_back(off[10:0]);
            exp_pdata_q.push_back(data);
            exp_pcyc_q.push_back(cycle);
            if (off == 25'd1) begin
                exp_hyper = (data == 8'hFF);
            end
        end else begin
            if (addr >= SCR_BASE && addr < OBJ_BASE) begin
                nw[3] = w[2];
                nw[2] = w[1];
                nw[1] = w[0];
                nw[0] = ~w[3];
            end else if (addr >= OBJ_BASE && addr < PCM_BASE) begin
                nw[4] = w[2];
                nw[3] = w[1];
                nw[2] = w[0];
                nw[1] = ~w[4];
                nw[0] = ~w[3];
            end
            exp_addr_q.push_back(nw);
            exp_data_q.push_back(data);
            exp_mask_q.push_back(addr[0] ? 2'b10 : 2'b01);
            exp_cyc_q.push_back(cycle);
            ack_dly_q.push_back(dly);
        end
    endtask

    // One ioctl write, then a gap long enough to avoid overflow
    task automatic send_write(input logic [24:0] addr, input logic [7:0] data, input int dly);
        int extra;
        @(negedge clk);
        ioctl_wr   = 1'b1;
        ioctl_addr = addr;
        ioctl_dout = data;
        if (downloading) begin
            predict(addr, data, dly);
        end
        @(negedge clk);
        ioctl_wr = 1'b0;
        if (is_hyper !== exp_hyper) begin
            $display("CHECK FAILED at %0t: is_hyper %b, expected %b", $time, is_hyper, exp_hyper);
            errors++;
        end
        rand_value(2, extra);
        repeat (dly + extra) @(negedge clk);
    endtask

    // SDRAM controller stand-in and output checker
    always @(negedge clk) begin
        int lat;
        if (arst_n) begin
            if (sdram_ack) begin
                pending = 1'b0;
            end
            if (prog_we && !pending) begin
                sdram_count++;
                if (exp_addr_q.size() == 0) begin
                    $display("Unexpected SDRAM write at %0t to word %h", $time, prog_addr);
                    errors++;
                    cur_dly = 0;
                end else begin
                    if (prog_addr !== exp_addr_q[0] || prog_data !== exp_data_q[0]
                        || prog_mask !== exp_mask_q[0]) begin
                        $display("CHECK FAILED at %0t: SDRAM write %h/%h/%b, expected %h/%h/%b",
                                 $time, prog_addr, prog_data, prog_mask,
                                 exp_addr_q[0], exp_data_q[0], exp_mask_q[0]);
                        errors++;
                    end
                    // Writes are spaced so the pipeline never stalls
                    lat = cycle - exp_cyc_q[0];
                    if (lat != 3) begin
                        $display("CHECK FAILED at %0t: SDRAM write latency %0d", $time, lat);
                        errors++;
                    end
                    void'(exp_addr_q.pop_front());
                    void'(exp_data_q.pop_front());
                    void'(exp_mask_q.pop_front());
                    void'(exp_cyc_q.pop_front());
                    cur_dly = ack_dly_q.pop_front();
                end
                pending   = 1'b1;
                wait_cnt  = 0;
                held_addr = prog_addr;
                held_data = prog_data;
                held_mask = prog_mask;
            end else if (prog_we) begin
                if (prog_addr !== held_addr || prog_data !== held_data
                    || prog_mask !== held_mask) begin
                    $display("CHECK FAILED at %0t: SDRAM write changed before sdram_ack", $time);
                    errors++;
                end
                wait_cnt++;
            end else if (pending) begin
                $display("prog_we dropped at %0t before sdram_ack was given", $time);
                errors++;
                pending = 1'b0;
            end
            sdram_ack = pending && (wait_cnt >= cur_dly);

            if (prom_we) begin
                prom_count++;
                if (exp_paddr_q.size() == 0) begin
                    $display("Unexpected PROM write at %0t to %h", $time, prom_addr);
                    errors++;
                end else begin
                    lat = cycle - exp_pcyc_q.pop_front();
                    if (prom_addr !== exp_paddr_q[0] || prom_data !== exp_pdata_q[0]) begin
                        $display("CHECK FAILED at %0t: PROM write %h/%h, expected %h/%h",
                                 $time, prom_addr, prom_data, exp_paddr_q[0], exp_pdata_q[0]);
                        errors++;
                    end
                    if (lat != 3) begin
                        $display("CHECK FAILED at %0t: PROM write latency %0d", $time, lat);
                        errors++;
                    end
                    void'(exp_paddr_q.pop_front());
                    void'(exp_pdata_q.pop_front());
                end
            end
        end
    end

    initial begin
        int          fd;
        int          n;
        int          dl;
        int          first;
        string       line;
        logic [24:0] a;
        logic [7:0]  d;
        fd = $fopen("dv/rom_load_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open dv/rom_load_patterns.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && $sscanf(line, "%h %h %d", a, d, dl) == 3) begin
                    pat_addr.push_back(a);
                    pat_data.push_back(d);
                    pat_dly.push_back(dl);
                end
            end
            $fclose(fd);
        end
        cycle_limit = pat_addr.size() * 40;
        first = (pat_addr.size() > 4) ? pat_addr.size() - 4 : 0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        if (prog_we || prom_we || dwnld_busy || is_hyper) begin
            $display("CHECK FAILED at %0t: outputs not low after reset", $time);
            errors++;
        end
        downloading = 1'b1;
        @(negedge clk);
        if (!dwnld_busy) begin
            $display("CHECK FAILED at %0t: dwnld_busy low while downloading", $time);
            errors++;
        end
        foreach (pat_addr[i]) begin
            send_write(pat_addr[i], pat_data[i], pat_dly[i]);
        end

        // Drain the pipeline
        downloading = 1'b0;
        while (exp_addr_q.size() != 0 || exp_paddr_q.size() != 0 || prog_we || prom_we) begin
            @(negedge clk);
        end
        @(negedge clk);
        if (dwnld_busy !== 1'b0) begin
            $display("CHECK FAILED at %0t: dwnld_busy still high after drain", $time);
            errors++;
        end

        // Same writes again with downloading low, all ignored
        for (int i = first; i < pat_addr.size(); i++) begin
            send_write(pat_addr[i], pat_data[i], pat_dly[i]);
        end
        repeat (8) @(negedge clk);

        $display("Errors: %0d, SDRAM writes: %0d, PROM writes: %0d",
                 errors, sdram_count, prom_count);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hw/rom_load_pkg.sv
hw/rom_dwnld_decode.sv
hw/gfx_addr_remap.sv
hw/sdram_prog_writer.sv
hw/rom_load_top.sv
dv/rom_load_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ROM download testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module rom_load_tb \
    -o rom_load_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rom_load_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" "$SIM_LOG"; then
    exit 0
fi
exit 1

//--- dv/rom_load_patterns.txt
// ROM download writes, one per line
// ioctl_addr (hex)  ioctl_dout (hex)  sdram_ack delay in cycles (decimal)
0000000 11 0
0000001 22 0
0000ABC 5A 2
000FFFF 3C 1
0010000 A1 0
0013FFF A2 3
0014000 B0 0
0014003 B1 1
001400E B3 2
0014011 B4 0
001BFFE B5 4
001C000 C0 0
001C009 C1 1
001C012 C2 0
001C01F C3 5
0023FFF C4 0
0024000 D0 0
0030001 D1 3
0033FFF D2 1
0034000 E0 0
0034001 FF 0
00347FF E3 0
0034800 F0 0
0100000 F1 0
1FFFFFF F2 0
0034001 07 0
0034001 FF 0
0000102 77 6
